// File: csr_subsystem.f
+incdir+source
source/csr_pkg.sv
source/csr_status_if.sv
source/csr_file.sv
source/csr_op_unit.sv
source/machine_timer.sv
source/trap_controller.sv
source/csr_subsystem.sv
testbench/tb_csr_subsystem.sv

// File: Bender.yml
package:
  name: csr_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/csr_pkg.sv
      - source/csr_status_if.sv
      - source/csr_file.sv
      - source/csr_op_unit.sv
      - source/machine_timer.sv
      - source/trap_controller.sv
      - source/csr_subsystem.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_csr_subsystem.sv

// File: testbench/tb_csr_subsystem.sv
/*
 * Testbench for the machine CSR subsystem. Table-driven CSR operations,
 * then timer interrupt entry and MRET.
 */
`timescale 1ns/1ps
`include "csr_settings.svh"

module tb_csr_subsystem import csr_pkg::*; ();

    localparam logic [`CSR_XLEN-1:0] TRAP_VEC  = 64'h0000_0000_8000_0100;  // Handler base.
    localparam logic [`CSR_XLEN-1:0] TRAP_PC   = 64'h0000_0000_8000_2a44;  // Interrupted PC.
    localparam logic [`CSR_XLEN-1:0] ST_TRAP   = 64'd1 << `MSTATUS_MPIE;   // MIE 0, MPIE 1.
    localparam logic [`CSR_XLEN-1:0] ST_RET    = ST_TRAP | (64'd1 << `MSTATUS_MIE);
    localparam logic [`CSR_XLEN-1:0] CAUSE_MTI = (64'd1 << 63) | 64'd7;  // Interrupt flag plus code 7.
    localparam int                   POLL_MAX  = 50;  // mip reads before giving up.

    logic                 clk;
    logic                 arst;
    logic                 i_op_valid;
    logic                 o_op_ready;
    csr_op_e              i_op;
    csr_idx_e             i_csr_idx;
    logic [`CSR_XLEN-1:0] i_operand;
    logic [`CSR_XLEN-1:0] o_rd_data;
    logic                 i_insn_boundary;
    logic [`CSR_XLEN-1:0] i_pc;
    logic                 o_redirect;
    logic [`CSR_XLEN-1:0] o_redirect_pc;

    // Stimulus table. One entry per row in each queue.
    string                row_name[$];
    csr_op_e              row_op[$];
    csr_idx_e             row_idx[$];
    logic [`CSR_XLEN-1:0] row_operand[$];
    logic [`CSR_XLEN-1:0] row_exp[$];
    bit                   row_chk[$];    // Compare read data.
    bit                   row_redir[$];  // Redirect expected next cycle.

    int                   errors;
    int                   checks;
    int                   redir_count;     // Redirect pulses seen.
    int                   first_trap_row;  // Rows from here run after the trap.
    int                   tries;
    logic [`CSR_XLEN-1:0] rnd [5];
    logic [`CSR_XLEN-1:0] last_rd;
    logic [`CSR_XLEN-1:0] t_a;
    logic [`CSR_XLEN-1:0] t_b;
    logic                 mip_seen;

    csr_subsystem i_dut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;  // 20 ns period.

    // Count redirect pulses mid-cycle.
    always @(negedge clk) begin
        if (o_redirect === 1'b1) redir_count++;
    end

    task automatic add_row(input string name, input csr_op_e op, input csr_idx_e idx,
                           input logic [`CSR_XLEN-1:0] operand,
                           input logic [`CSR_XLEN-1:0] exp_rd, input bit chk, input bit redir);
        row_name.push_back(name);
        row_op.push_back(op);
        row_idx.push_back(idx);
        row_operand.push_back(operand);
        row_exp.push_back(exp_rd);
        row_chk.push_back(chk);
        row_redir.push_back(redir);
    endtask

    // One CSR request. Holds it until ready, checks read data and redirect.
    task automatic run_op(input string name, input csr_op_e op, input csr_idx_e idx,
                          input logic [`CSR_XLEN-1:0] operand,
                          input logic [`CSR_XLEN-1:0] exp_rd, input bit chk, input bit exp_redir,
                          input logic [`CSR_XLEN-1:0] exp_pc, output logic [`CSR_XLEN-1:0] act);
        @(posedge clk);
        #2;
        i_op_valid = 1'b1;
        i_op       = op;
        i_csr_idx  = idx;
        i_operand  = operand;
        @(negedge clk);
        while (o_op_ready !== 1'b1) @(negedge clk);  // Stalled by trap FSM.
        act = o_rd_data;  // Old value in the accepting cycle.
        checks++;
        if (chk && o_rd_data !== exp_rd) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp_rd, o_rd_data);
        end
        @(posedge clk);
        #2;
        i_op_valid = 1'b0;
        @(negedge clk);
        if (o_redirect !== exp_redir) begin
            errors++;
            $display("MISMATCH %s redirect: expected %b, actual %b", name, exp_redir, o_redirect);
        end
        if (exp_redir && o_redirect_pc !== exp_pc) begin
            errors++;
            $display("MISMATCH %s target: expected %h, actual %h", name, exp_pc, o_redirect_pc);
        end
    endtask

    // ----------------------------
    // Main sequence.
    // ----------------------------
    initial begin
        void'($urandom(32'h2053_b127));
        errors = 0;
        checks = 0;
        redir_count = 0;
        arst = 1'b1;
        i_op_valid = 1'b0;
        i_op = CSR_RW;
        i_csr_idx = IDX_MSTATUS;
        i_operand = '0;
        i_insn_boundary = 1'b0;
        i_pc = '0;
        for (int k = 0; k < 5; k++) begin
            rnd[k] = {$urandom, $urandom};
        end

        // Reset values. RS with zero operand is a plain read.
        add_row("rst_mstatus", CSR_RS, IDX_MSTATUS, '0, '0, 1, 0);
        add_row("rst_mie", CSR_RS, IDX_MIE, '0, '0, 1, 0);
        add_row("rst_mtvec", CSR_RS, IDX_MTVEC, '0, '0, 1, 0);
        add_row("rst_mcause", CSR_RS, IDX_MCAUSE, '0, '0, 1, 0);
        add_row("rst_mepc", CSR_RS, IDX_MEPC, '0, '0, 1, 0);
        add_row("rst_mip", CSR_RS, IDX_MIP, '0, '0, 1, 0);
        add_row("rw_mtvec", CSR_RW, IDX_MTVEC, rnd[0], '0, 1, 0);
        add_row("rd_mtvec", CSR_RS, IDX_MTVEC, '0, rnd[0], 1, 0);
        // Set and clear rules.
        add_row("rs_mie", CSR_RS, IDX_MIE, rnd[1], '0, 1, 0);
        add_row("rc_mie", CSR_RC, IDX_MIE, rnd[2], rnd[1], 1, 0);
        add_row("rd_mie", CSR_RS, IDX_MIE, '0, rnd[1] & ~rnd[2], 1, 0);
        add_row("rs_mtvec", CSR_RS, IDX_MTVEC, rnd[3], rnd[0], 1, 0);
        add_row("rc_mtvec", CSR_RC, IDX_MTVEC, rnd[4], rnd[0] | rnd[3], 1, 0);
        add_row("rd_mtvec2", CSR_RS, IDX_MTVEC, '0, (rnd[0] | rnd[3]) & ~rnd[4], 1, 0);
        // Read-only CSRs.
        add_row("wr_mip", CSR_RW, IDX_MIP, '1, '0, 1, 0);
        add_row("rd_mip", CSR_RS, IDX_MIP, '0, '0, 1, 0);
        add_row("wr_mtime", CSR_RW, IDX_MTIME, '0, '0, 0, 0);
        first_trap_row = row_name.size();
        // State left by the trap, then MRET.
        add_row("mepc_saved", CSR_RS, IDX_MEPC, '0, TRAP_PC, 1, 0);
        add_row("mcause_mti", CSR_RS, IDX_MCAUSE, '0, CAUSE_MTI, 1, 0);
        add_row("mstatus_trap", CSR_RS, IDX_MSTATUS, '0, ST_TRAP, 1, 0);
        add_row("mret", CSR_MRET, IDX_MSTATUS, '0, ST_TRAP, 1, 1);
        add_row("mstatus_ret", CSR_RS, IDX_MSTATUS, '0, ST_RET, 1, 0);

        repeat (5) @(posedge clk);
        #2;
        arst = 1'b0;

        for (int r = 0; r < first_trap_row; r++) begin
            run_op(row_name[r], row_op[r], row_idx[r], row_operand[r], row_exp[r],
                   row_chk[r], row_redir[r], TRAP_PC, last_rd);
        end

        // Timer with MTIE clear -----
        run_op("mtie_clr", CSR_RW, IDX_MIE, '0, '0, 0, 0, '0, t_a);
        run_op("mtime_a", CSR_RS, IDX_MTIME, '0, '0, 0, 0, '0, t_a);
        run_op("mtime_b", CSR_RS, IDX_MTIME, '0, '0, 0, 0, '0, t_b);
        if (t_a <= last_rd) begin
            errors++;
            $display("ERROR: mtime fell back after a software write to it");
        end
        if (t_b <= t_a) begin
            errors++;
            $display("ERROR: mtime did not advance between two reads");
        end
        run_op("mie_set", CSR_RW, IDX_MSTATUS, 64'd1 << `MSTATUS_MIE, '0, 0, 0, '0, t_a);
        run_op("cmp_set", CSR_RW, IDX_MTIMECMP, t_b + 64'd16, '0, 0, 0, '0, t_a);
        @(posedge clk);
        #2;
        i_insn_boundary = 1'b1;  // Only MTIE keeps the trap out.
        tries = 0;
        mip_seen = 1'b0;
        while (!mip_seen && tries < POLL_MAX) begin
            run_op("mip_poll", CSR_RS, IDX_MIP, '0, '0, 0, 0, '0, t_a);
            mip_seen = t_a[`MIP_MTIP];
            tries++;
        end
        @(posedge clk);
        #2;
        i_insn_boundary = 1'b0;
        if (!mip_seen) begin
            errors++;
            $display("ERROR: mip MTIP never set after mtimecmp was passed");
        end
        if (redir_count != 0) begin
            errors++;
            $display("ERROR: fetch redirect seen while MTIE was clear");
        end

        // Trap entry ----------------
        run_op("tvec_set", CSR_RW, IDX_MTVEC, TRAP_VEC, '0, 0, 0, '0, t_a);
        run_op("mtie_set", CSR_RW, IDX_MIE, 64'd1 << `MIE_MTIE, '0, 0, 0, '0, t_a);
        @(posedge clk);
        #2;
        i_pc = TRAP_PC;
        i_insn_boundary = 1'b1;  // Retire with the interrupt pending.
        @(negedge clk);
        checks++;
        if (o_op_ready !== 1'b0) begin
            errors++;
            $display("MISMATCH trap_take_ready: expected 0, actual %b", o_op_ready);
        end
        while (o_redirect !== 1'b1) @(negedge clk);
        checks++;
        if (o_redirect_pc !== TRAP_VEC) begin
            errors++;
            $display("MISMATCH trap_target: expected %h, actual %h", TRAP_VEC, o_redirect_pc);
        end
        if (o_op_ready !== 1'b0) begin
            errors++;
            $display("MISMATCH trap_redirect_ready: expected 0, actual %b", o_op_ready);
        end
        @(posedge clk);
        #2;
        i_insn_boundary = 1'b0;
        @(negedge clk);
        if (o_op_ready !== 1'b0) begin
            errors++;
            $display("MISMATCH trap_hold_ready: expected 0, actual %b", o_op_ready);
        end
        @(negedge clk);
        if (o_op_ready !== 1'b1) begin
            errors++;
            $display("MISMATCH trap_resume_ready: expected 1, actual %b", o_op_ready);
        end
        repeat (2) @(negedge clk);
        if (redir_count != 1) begin
            errors++;
            $display("ERROR: trap entry gave %0d redirect pulses instead of one", redir_count);
        end

        for (int r = first_trap_row; r < row_name.size(); r++) begin
            run_op(row_name[r], row_op[r], row_idx[r], row_operand[r], row_exp[r],
                   row_chk[r], row_redir[r], TRAP_PC, last_rd);
        end
        if (redir_count != 2) begin
            errors++;
            $display("ERROR: MRET left %0d redirect pulses in total, two expected", redir_count);
        end

        $display("Done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog. Budget scales with the table.
    initial begin
        #1;
        repeat (row_name.size() * 200) @(posedge clk);
        $display("ERROR: watchdog expired, the DUT stopped responding");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: source/csr_subsystem.sv
/*
 * Machine-mode CSR and timer interrupt subsystem. Top level.
 */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_subsystem import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 arst,
    // Core CSR request.
    input  logic                 i_op_valid,
    output logic                 o_op_ready,
    input  csr_op_e              i_op,
    input  csr_idx_e             i_csr_idx,
    input  logic [`CSR_XLEN-1:0] i_operand,
    output logic [`CSR_XLEN-1:0] o_rd_data,  // Old CSR value.
    // Retire and fetch redirect.
    input  logic                 i_insn_boundary,
    input  logic [`CSR_XLEN-1:0] i_pc,
    output logic                 o_redirect,
    output logic [`CSR_XLEN-1:0] o_redirect_pc
);

    // Internal wiring ---------------
    logic                 wr_en;
    csr_idx_e             wr_idx;
    logic [`CSR_XLEN-1:0] wr_data;
    logic                 cmp_we;
    logic [`CSR_XLEN-1:0] cmp_data;
    logic [`CSR_XLEN-1:0] mtime;
    logic [`CSR_XLEN-1:0] mtimecmp;
    logic                 timer_pending;
    logic                 mret;

    csr_status_if u_status ();

    csr_op_unit u_op (
        .i_valid    (i_op_valid),
        .i_ready    (o_op_ready),
        .i_op       (i_op),
        .i_operand  (i_operand),
        .i_old_data (o_rd_data),
        .i_idx      (i_csr_idx),
        .o_wr_en    (wr_en),
        .o_wr_idx   (wr_idx),
        .o_wr_data  (wr_data),
        .o_cmp_we   (cmp_we),
        .o_cmp_data (cmp_data),
        .o_mret     (mret)
    );

    csr_file u_file (
        .clk             (clk),
        .arst            (arst),
        .i_wr_en         (wr_en),
        .i_wr_idx        (wr_idx),
        .i_wr_data       (wr_data),
        .i_rd_idx        (i_csr_idx),
        .i_mtime         (mtime),
        .i_mtimecmp      (mtimecmp),
        .i_timer_pending (timer_pending),
        .o_rd_data       (o_rd_data),
        .status          (u_status.file)
    );

    machine_timer u_timer (
        .clk             (clk),
        .arst            (arst),
        .i_cmp_we        (cmp_we),
        .i_cmp_data      (cmp_data),
        .o_mtime         (mtime),
        .o_mtimecmp      (mtimecmp),
        .o_timer_pending (timer_pending)
    );

    trap_controller u_ctrl (
        .clk             (clk),
        .arst            (arst),
        .i_insn_boundary (i_insn_boundary),
        .i_pc            (i_pc),
        .i_mret          (mret),
        .status          (u_status.ctrl),
        .o_op_ready      (o_op_ready),
        .o_redirect      (o_redirect),
        .o_redirect_pc   (o_redirect_pc)
    );

endmodule

// File: source/trap_controller.sv
/*
 * Trap controller. Takes the timer interrupt at an instruction boundary,
 * handles MRET and drives the one-cycle fetch redirect.
 */
`timescale 1ns/1ps
`include "csr_settings.svh"

module trap_controller import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 arst,
    input  logic                 i_insn_boundary,
    input  logic [`CSR_XLEN-1:0] i_pc,
    input  logic                 i_mret,
    csr_status_if.ctrl           status,
    output logic                 o_op_ready,
    output logic                 o_redirect,
    output logic [`CSR_XLEN-1:0] o_redirect_pc
);

    trap_state_e          state;
    trap_state_e          state_nxt;
    logic                 take_irq;      // Interrupt taken this cycle.
    logic [`CSR_XLEN-1:0] redirect_pc_q; // Latched target.

    // ------------------------------
    // Interrupt decision.
    // ------------------------------
    assign take_irq = (state == ST_RUN) && i_insn_boundary &&
                      status.mie_on && status.mtie_on && status.mip_mtip;

    assign status.trap_enter  = take_irq;
    assign status.trap_pc     = i_pc;    // Saved as mepc.
    assign status.trap_return = i_mret;  // Only accepted in ST_RUN.

    // ------------------------------
    // State machine.
    // ------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_RUN: begin
                if (take_irq || i_mret) begin
                    state_nxt = ST_REDIRECT;
                end
            end
            ST_REDIRECT: state_nxt = ST_HOLD;  // Let MIE settle.
            ST_HOLD:     state_nxt = ST_RUN;
            default:     state_nxt = ST_RUN;
        endcase
    end

    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            state <= ST_RUN;
        end else begin
            state <= state_nxt;
        end
    end

    // Redirect target. mtvec on entry, mepc on MRET.
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            redirect_pc_q <= '0;
        end else if (take_irq) begin
            redirect_pc_q <= status.mtvec_val;
        end else if (i_mret) begin
            redirect_pc_q <= status.mepc_val;
        end
    end

    // Outputs -----------------------
    assign o_op_ready    = (state == ST_RUN) && !take_irq;  // Stall through trap.
    assign o_redirect    = (state == ST_REDIRECT);
    assign o_redirect_pc = redirect_pc_q;

    // Redirect is a single-cycle pulse.
    assert property (@(posedge clk) disable iff (arst)
        o_redirect |=> !o_redirect);

endmodule

// File: source/machine_timer.sv
/*
 * Machine timer. Free-running mtime, writable mtimecmp, registered pending.
 */
`timescale 1ns/1ps
`include "csr_settings.svh"

module machine_timer (
    input  logic                 clk,
    input  logic                 arst,
    input  logic                 i_cmp_we,
    input  logic [`CSR_XLEN-1:0] i_cmp_data,
    output logic [`CSR_XLEN-1:0] o_mtime,
    output logic [`CSR_XLEN-1:0] o_mtimecmp,
    output logic                 o_timer_pending
);

    logic [`CSR_XLEN-1:0] mtime_q;
    logic [`CSR_XLEN-1:0] mtimecmp_q;
    logic                 pending_q;

    // ------------------------------
    // Counter, compare and pending.
    // ------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;  // Far future. No interrupt out of reset.
            pending_q  <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 1'b1;  // Ticks every cycle.
            if (i_cmp_we) begin
                mtimecmp_q <= i_cmp_data;
            end
            // Registered compare. Adds one cycle of latency.
            pending_q <= (mtime_q >= mtimecmp_q);
        end
    end

    assign o_mtime         = mtime_q;
    assign o_mtimecmp      = mtimecmp_q;
    assign o_timer_pending = pending_q;

    // mtime only goes backwards on wrap.
    assert property (@(posedge clk) disable iff (arst)
        (o_mtime != '1) |=> (o_mtime >= $past(o_mtime)));

endmodule

// File: source/csr_op_unit.sv
/*
 * CSR operation unit. Forms the read-modify-write value and steers it
 * to the CSR file or to the timer compare register.
 */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_op_unit import csr_pkg::*; (
    input  logic                 i_valid,
    input  logic                 i_ready,
    input  csr_op_e              i_op,
    input  logic [`CSR_XLEN-1:0] i_operand,
    input  logic [`CSR_XLEN-1:0] i_old_data,
    input  csr_idx_e             i_idx,
    output logic                 o_wr_en,
    output csr_idx_e             o_wr_idx,
    output logic [`CSR_XLEN-1:0] o_wr_data,
    output logic                 o_cmp_we,
    output logic [`CSR_XLEN-1:0] o_cmp_data,
    output logic                 o_mret
);

    logic                 accept;   // Handshake this cycle.
    logic                 do_write; // Op modifies the CSR.
    logic [`CSR_XLEN-1:0] new_val;

    assign accept = i_valid && i_ready;

    // New value by op.
    always_comb begin
        case (i_op)
            CSR_RS:  new_val = i_old_data | i_operand;
            CSR_RC:  new_val = i_old_data & ~i_operand;
            default: new_val = i_operand;  // RW. Unused for MRET.
        endcase
    end

    // Set/clear with zero operand is a pure read.
    assign do_write = accept && (i_op != CSR_MRET) &&
                      ((i_op == CSR_RW) || (i_operand != '0));

    // Steering ------------------------
    assign o_wr_en    = do_write && (i_idx != IDX_MTIMECMP);
    assign o_wr_idx   = i_idx;
    assign o_wr_data  = new_val;
    assign o_cmp_we   = do_write && (i_idx == IDX_MTIMECMP);  // Timer owns it.
    assign o_cmp_data = new_val;
    assign o_mret     = accept && (i_op == CSR_MRET);

endmodule

// File: source/csr_file.sv
/*
 * Machine CSR file. One write port, combinational read, MTIP tracking,
 * and the mstatus/mepc/mcause updates of trap entry and MRET.
 */
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_file import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 arst,
    input  logic                 i_wr_en,
    input  csr_idx_e             i_wr_idx,
    input  logic [`CSR_XLEN-1:0] i_wr_data,
    input  csr_idx_e             i_rd_idx,
    input  logic [`CSR_XLEN-1:0] i_mtime,
    input  logic [`CSR_XLEN-1:0] i_mtimecmp,
    input  logic                 i_timer_pending,
    output logic [`CSR_XLEN-1:0] o_rd_data,
    csr_status_if.file           status
);

    logic [`CSR_XLEN-1:0] mstatus;
    logic [`CSR_XLEN-1:0] mie;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mepc;
    logic                 mtip_q;    // Only live mip bit.
    logic [`CSR_XLEN-1:0] mip_word;  // mip as read.

    // ------------------------------
    // Register updates.
    // ------------------------------
    always_ff @(posedge clk or posedge arst) begin
        if (arst) begin
            mstatus <= '0;
            mie     <= '0;
            mtvec   <= '0;
            mcause  <= '0;
            mepc    <= '0;
            mtip_q  <= 1'b0;
        end else begin
            mtip_q <= i_timer_pending;  // MTIP mirrors timer.
            if (i_wr_en) begin
                case (i_wr_idx)
                    IDX_MSTATUS: mstatus <= i_wr_data;
                    IDX_MIE:     mie     <= i_wr_data;
                    IDX_MTVEC:   mtvec   <= i_wr_data;
                    IDX_MCAUSE:  mcause  <= i_wr_data;
                    IDX_MEPC:    mepc    <= i_wr_data;
                    default: ;  // mtime and mip are read-only.
                endcase
            end
            // Trap updates come last so they override a software write.
            if (status.trap_enter) begin
                mepc                   <= status.trap_pc;
                mcause                 <= `CSR_CAUSE_MTI;
                mstatus[`MSTATUS_MPIE] <= mstatus[`MSTATUS_MIE];  // Stack MIE.
                mstatus[`MSTATUS_MIE]  <= 1'b0;                   // Mask further traps.
            end else if (status.trap_return) begin
                mstatus[`MSTATUS_MIE]  <= mstatus[`MSTATUS_MPIE];  // Unstack.
                mstatus[`MSTATUS_MPIE] <= 1'b1;
            end
        end
    end

    // ------------------------------
    // Read side.
    // ------------------------------
    always_comb begin
        mip_word            = '0;
        mip_word[`MIP_MTIP] = mtip_q;
    end

    always_comb begin
        case (i_rd_idx)
            IDX_MSTATUS:  o_rd_data = mstatus;
            IDX_MTIME:    o_rd_data = i_mtime;
            IDX_MIE:      o_rd_data = mie;
            IDX_MTVEC:    o_rd_data = mtvec;
            IDX_MCAUSE:   o_rd_data = mcause;
            IDX_MEPC:     o_rd_data = mepc;
            IDX_MIP:      o_rd_data = mip_word;
            IDX_MTIMECMP: o_rd_data = i_mtimecmp;
            default:      o_rd_data = '0;
        endcase
    end

    // Status toward the trap controller.
    assign status.mie_on    = mstatus[`MSTATUS_MIE];
    assign status.mtie_on   = mie[`MIE_MTIE];
    assign status.mip_mtip  = mtip_q;
    assign status.mtvec_val = mtvec;
    assign status.mepc_val  = mepc;

    // Controller must never enter and return in one cycle.
    assert property (@(posedge clk) disable iff (arst)
        !(status.trap_enter && status.trap_return));

endmodule

// File: source/csr_status_if.sv
/*
 * Status and trap command bundle between the CSR file and trap controller.
 */
`timescale 1ns/1ps
`include "csr_settings.svh"

interface csr_status_if;

    // File to controller.
    logic                 mie_on;     // mstatus.MIE.
    logic                 mtie_on;    // mie.MTIE.
    logic                 mip_mtip;   // mip.MTIP.
    logic [`CSR_XLEN-1:0] mtvec_val;  // Trap target.
    logic [`CSR_XLEN-1:0] mepc_val;   // Return target.

    // Controller to file.
    logic                 trap_enter;   // Take the timer interrupt.
    logic [`CSR_XLEN-1:0] trap_pc;      // PC to save in mepc.
    logic                 trap_return;  // MRET accepted.

    modport file (
        output mie_on, mtie_on, mip_mtip, mtvec_val, mepc_val,
        input  trap_enter, trap_pc, trap_return
    );

    modport ctrl (
        input  mie_on, mtie_on, mip_mtip, mtvec_val, mepc_val,
        output trap_enter, trap_pc, trap_return
    );

endinterface

// File: source/csr_pkg.sv
/*
 * Machine CSR package. Operation codes, CSR index map and trap FSM states.
 */
`include "csr_settings.svh"

package csr_pkg;

    // ------------------------------
    // CSR operations from the core.
    // ------------------------------
    typedef enum logic [1:0] {
        CSR_RW   = 2'd0,  // Write operand.
        CSR_RS   = 2'd1,  // Set operand bits.
        CSR_RC   = 2'd2,  // Clear operand bits.
        CSR_MRET = 2'd3   // Trap return.
    } csr_op_e;

    // ------------------------------
    // CSR index map.
    // ------------------------------
    typedef enum logic [`CSR_IDX_W-1:0] {
        IDX_MSTATUS  = 3'd0,
        IDX_MTIME    = 3'd1,  // Read-only.
        IDX_MIE      = 3'd2,
        IDX_MTVEC    = 3'd3,
        IDX_MCAUSE   = 3'd4,
        IDX_MEPC     = 3'd5,
        IDX_MIP      = 3'd6,  // Read-only.
        IDX_MTIMECMP = 3'd7   // Lives in the timer.
    } csr_idx_e;

    // Trap controller states. Hold is a settle cycle after a redirect.
    typedef enum logic [1:0] {
        ST_RUN      = 2'd0,
        ST_REDIRECT = 2'd1,
        ST_HOLD     = 2'd2
    } trap_state_e;

endpackage

// File: source/csr_settings.svh
/*
 * Machine CSR block settings. Widths, trap cause and CSR bit positions.
 */
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Data path widths ------------
`define CSR_XLEN   64  // CSR and PC width.
`define CSR_IDX_W  3   // CSR index width.

// Machine timer interrupt cause. Interrupt flag plus code 7.
`define CSR_CAUSE_MTI 64'h8000_0000_0000_0007

// Bit positions ---------------
`define MSTATUS_MIE   3  // Global interrupt enable.
`define MSTATUS_MPIE  7  // Previous MIE.
`define MIE_MTIE      7  // Timer interrupt enable.
`define MIP_MTIP      7  // Timer interrupt pending.

`endif
